// ==== Makefile ====
# Verilator build and run for the platform glue testbench

VERILATOR ?= verilator
TOP       ?= kvb_platform_tb
SEED      ?= 2484389288
FILELIST  ?= kvb_platform_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) SEED=$(SEED)"

test:
	$(VERILATOR) --binary --assert --timing --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr \
		| grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/kvb_platform_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module kvb_platform_props #(
    parameter int RELEASE_DELAY    = kvb_platform_pkg::DEF_RELEASE_DELAY,
    parameter int DEBOUNCE_LEN     = kvb_platform_pkg::DEF_DEBOUNCE_LEN,
    parameter int SYNC_HALF_PERIOD = kvb_platform_pkg::DEF_SYNC_HALF_PERIOD
) (
    input wire                         clk125,
    input wire                         sys_rst_n,
    input wire                         voltage_alert,
    input wire                         power_failure_n,
    input kvb_platform_pkg::slot_vec_t slot_prsnt_n,
    input kvb_platform_pkg::ltssm_t    ltssm,
    input kvb_platform_pkg::user_led_t user_led,
    input kvb_platform_pkg::alarm_t    alarms,
    input kvb_platform_pkg::slot_vec_t slot_sync_clk,
    input kvb_platform_pkg::slot_vec_t slot_clk_oe,
    input kvb_platform_pkg::slot_vec_t clk_req_oe,
    input wire                         link_led_n,
    input kvb_platform_pkg::user_led_t user_led_n
);

    import kvb_platform_pkg::*;

    logic [15:0] rel_cnt;
    slot_vec_t   exp_prsnt;
    logic        wave;
    logic        last_wave;
    logic        wave_seen;
    logic [15:0] phase_len;
    alarm_t      alarm_raw;
    logic [7:0]  act_run [2];
    logic [7:0]  idle_run [2];
    alarm_t      long_act;
    alarm_t      long_idle;
    alarm_t      full_act;
    alarm_t      full_idle;

    // One flag per check, watched by the testbench
    logic fail_oe = 1'b0;
    logic fail_req = 1'b0;
    logic fail_gate = 1'b0;
    logic fail_phase = 1'b0;
    logic fail_alarm = 1'b0;
    logic fail_led = 1'b0;
    logic fail_rst = 1'b0;
    logic any_fail;

    assign any_fail = fail_oe | fail_req | fail_gate | fail_phase | fail_alarm
                    | fail_led | fail_rst;

    ////////////////////////////////////////
    // Reference trackers
    ////////////////////////////////////////

    // Edges since reset release, saturating
    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rel_cnt <= '0;
        end else if (rel_cnt != '1) begin
            rel_cnt <= rel_cnt + 1'b1;
        end
    end

    // Presence seen up to the second edge after release
    always_ff @(posedge clk125) begin
        if (rel_cnt < 16'd2) begin
            exp_prsnt <= ~slot_prsnt_n;
        end
    end

    // Phase length of the gated wave
    assign wave = |slot_sync_clk;
    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            last_wave <= 1'b0;
            wave_seen <= 1'b0;
            phase_len <= '0;
        end else begin
            last_wave <= wave;
            if (wave != last_wave) begin
                wave_seen <= 1'b1;
                phase_len <= 16'd1;
            end else if (phase_len != '1) begin
                phase_len <= phase_len + 1'b1;
            end
        end
    end

    // Run lengths of each raw alarm, active high
    assign alarm_raw = {~power_failure_n, voltage_alert};
    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            act_run  <= '{default: '0};
            idle_run <= '{default: '0};
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (alarm_raw[i]) begin
                    idle_run[i] <= '0;
                    act_run[i]  <= (act_run[i] == 8'hff) ? act_run[i] : act_run[i] + 1'b1;
                end else begin
                    act_run[i]  <= '0;
                    idle_run[i] <= (idle_run[i] == 8'hff) ? idle_run[i] : idle_run[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            long_act[i]  = act_run[i] >= DEBOUNCE_LEN;
            long_idle[i] = idle_run[i] >= DEBOUNCE_LEN;
            full_act[i]  = act_run[i] >= DEBOUNCE_LEN + 1;
            full_idle[i] = idle_run[i] >= DEBOUNCE_LEN + 1;
        end
    end

    ////////////////////////////////////////
    // Slot clocks
    ////////////////////////////////////////

    a_oe: assert property (@(posedge clk125) disable iff (!sys_rst_n)
        slot_clk_oe == ((rel_cnt >= RELEASE_DELAY + 3) ? exp_prsnt : '0))
        else begin
            fail_oe = 1'b1;
            $error("FAILED slot_clk_oe=%h at release cycle %0d", slot_clk_oe, rel_cnt);
        end

    a_req: assert property (@(posedge clk125) disable iff (!sys_rst_n)
        (rel_cnt >= 16'd2) |-> clk_req_oe == exp_prsnt)
        else begin
            fail_req = 1'b1;
            $error("FAILED clk_req_oe=%h expected %h", clk_req_oe, exp_prsnt);
        end

    // Absent slots dark, present slots share one wave
    a_gate: assert property (@(posedge clk125) disable iff (!sys_rst_n)
        (rel_cnt >= 16'd2) |-> slot_sync_clk == ({NUM_SLOTS{wave}} & exp_prsnt))
        else begin
            fail_gate = 1'b1;
            $error("FAILED slot_sync_clk=%h presence %h", slot_sync_clk, exp_prsnt);
        end

    // Wave keeps toggling, each full phase lasts one half period
    a_phase: assert property (@(posedge clk125) disable iff (!sys_rst_n)
        (exp_prsnt != '0) |-> (phase_len <= SYNC_HALF_PERIOD)
        && (!(wave_seen && wave != last_wave) || phase_len == SYNC_HALF_PERIOD))
        else begin
            fail_phase = 1'b1;
            $error("FAILED slot_sync_clk phase length=%h", phase_len);
        end

    ////////////////////////////////////////
    // Alarms
    ////////////////////////////////////////

    // No edge without a full agreeing window, and a long level must win
    a_alarm: assert property (@(posedge clk125) disable iff (!sys_rst_n)
        ((alarms & ~$past(alarms) & ~$past(long_act)) == '0)
        && ((~alarms & $past(alarms) & ~$past(long_idle)) == '0)
        && ((full_act & ~alarms) == '0) && ((full_idle & alarms) == '0))
        else begin
            fail_alarm = 1'b1;
            $error("FAILED alarms=%h raw=%h", alarms, alarm_raw);
        end

    ////////////////////////////////////////
    // LEDs
    ////////////////////////////////////////

    a_led: assert property (@(posedge clk125) disable iff (!sys_rst_n)
        $past(sys_rst_n) |-> (link_led_n == !($past(ltssm) == LTSSM_L0
        || $past(ltssm) == LTSSM_L0S)) && (user_led_n == ~$past(user_led)))
        else begin
            fail_led = 1'b1;
            $error("FAILED link_led_n=%h user_led_n=%h", link_led_n, user_led_n);
        end

    // Outputs after any edge taken in reset
    a_rst: assert property (@(posedge clk125)
        !sys_rst_n |=> link_led_n && user_led_n == '1 && alarms == '0 && slot_clk_oe == '0)
        else begin
            fail_rst = 1'b1;
            $error("FAILED outputs in reset link_led_n=%h user_led_n=%h", link_led_n, user_led_n);
        end

endmodule

`default_nettype wire

// ==== dv/kvb_platform_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module kvb_platform_tb;

    import kvb_platform_pkg::*;

    parameter int unsigned SEED = 32'h9414c5a8;

    localparam int HALF       = 8;
    localparam int DEB        = DEF_DEBOUNCE_LEN;
    localparam int MAX_CYCLES = 4000;

    logic      clk125;
    logic      sys_rst_n;
    logic      voltage_alert;
    logic      power_failure_n;
    slot_vec_t slot_prsnt_n;
    ltssm_t    ltssm;
    user_led_t user_led;
    alarm_t    alarms;
    slot_vec_t slot_sync_clk;
    slot_vec_t slot_clk_oe;
    slot_vec_t clk_req_oe;
    logic      link_led_n;
    user_led_t user_led_n;
    int        cycle_cnt = 0;

    kvb_platform_top #(
        .SYNC_HALF_PERIOD (HALF)
    ) DUT (
        .clk125 (clk125), .sys_rst_n (sys_rst_n),
        .voltage_alert (voltage_alert), .power_failure_n (power_failure_n),
        .slot_prsnt_n (slot_prsnt_n), .ltssm (ltssm), .user_led (user_led),
        .alarms (alarms), .slot_sync_clk (slot_sync_clk), .slot_clk_oe (slot_clk_oe),
        .clk_req_oe (clk_req_oe), .link_led_n (link_led_n), .user_led_n (user_led_n)
    );

    bind kvb_platform_top kvb_platform_props #(
        .RELEASE_DELAY (RELEASE_DELAY), .DEBOUNCE_LEN (DEBOUNCE_LEN),
        .SYNC_HALF_PERIOD (SYNC_HALF_PERIOD)
    ) u_props (
        .clk125 (clk125), .sys_rst_n (sys_rst_n),
        .voltage_alert (voltage_alert), .power_failure_n (power_failure_n),
        .slot_prsnt_n (slot_prsnt_n), .ltssm (ltssm), .user_led (user_led),
        .alarms (alarms), .slot_sync_clk (slot_sync_clk), .slot_clk_oe (slot_clk_oe),
        .clk_req_oe (clk_req_oe), .link_led_n (link_led_n), .user_led_n (user_led_n)
    );

    initial begin
        clk125 = 1'b0;
        forever #4 clk125 = ~clk125;
    end

    ////////////////////////////////////////
    // Run limit and failure watch
    ////////////////////////////////////////

    always @(posedge clk125) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "Simulation ran past the cycle limit");
        end
    end

    // Assertion flags settle on the rising edge
    always @(negedge clk125) begin
        if (DUT.u_props.any_fail) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "An assertion in the bound checker failed");
        end
    end

    // Leaves the caller just after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk125);
        #1;
    endtask

    // At least one slot present
    function automatic slot_vec_t random_presence();
        slot_vec_t v;
        v = slot_vec_t'($urandom);
        if (v == '0) begin
            v[0] = 1'b1;
        end
        return v;
    endfunction

    task automatic reset_board(input slot_vec_t present);
        int waited;
        sys_rst_n    = 1'b0;
        slot_prsnt_n = ~present;
        wait_cycles(4);
        sys_rst_n = 1'b1;
        wait_cycles(2);
        // Latched by now, later changes must not matter
        slot_prsnt_n = slot_vec_t'($urandom);
        waited = 0;
        while (slot_clk_oe == '0) begin
            if (waited > 2 * DEF_RELEASE_DELAY) begin
                $display("TEST RESULT: FAIL");
                $fatal(1, "Slot clock enables never came up after reset");
            end
            wait_cycles(1);
            waited++;
        end
        wait_cycles(6 * HALF);
        slot_prsnt_n = slot_vec_t'($urandom);
        wait_cycles(6 * HALF);
    endtask

    task automatic drive_alarm(input int sel, input logic level);
        if (sel == 0) begin
            voltage_alert = level;
        end else begin
            power_failure_n = ~level;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        sys_rst_n       = 1'b0;
        voltage_alert   = 1'b0;
        power_failure_n = 1'b1;
        slot_prsnt_n    = '1;
        ltssm           = '0;
        user_led        = '0;
        void'($urandom(SEED));

        // Two reset runs with fresh presence
        reset_board(random_presence());
        reset_board(random_presence());

        // Short glitches, then a held level with a dip inside
        for (int sel = 0; sel < 2; sel++) begin
            for (int g = 0; g < 4; g++) begin
                drive_alarm(sel, 1'b1);
                wait_cycles(1 + int'($urandom % (DEB - 1)));
                drive_alarm(sel, 1'b0);
                wait_cycles(DEB + 4);
            end
            drive_alarm(sel, 1'b1);
            wait_cycles(DEB + 3);
            drive_alarm(sel, 1'b0);
            wait_cycles(1 + int'($urandom % (DEB - 1)));
            drive_alarm(sel, 1'b1);
            wait_cycles(DEB + 3);
            drive_alarm(sel, 1'b0);
            wait_cycles(DEB + 4);
        end

        // LTSSM codes and user LEDs, link-up codes mixed in
        for (int i = 0; i < 200; i++) begin
            case (i % 10)
                3: ltssm = LTSSM_L0;
                7: ltssm = LTSSM_L0S;
                default: ltssm = ltssm_t'($urandom);
            endcase
            user_led = user_led_t'($urandom);
            wait_cycles(1);
        end
        ltssm = '0;
        wait_cycles(4);

        if (DUT.u_props.any_fail) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "An assertion in the bound checker failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/alarm_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module alarm_filter #(
    parameter int DEBOUNCE_LEN = kvb_platform_pkg::DEF_DEBOUNCE_LEN
) (
    input  wire                      clk125,
    input  wire                      sys_rst_n,
    input  wire                      voltage_alert,
    input  wire                      power_failure_n,
    output kvb_platform_pkg::alarm_t alarms
);

    import kvb_platform_pkg::*;

    // One history per alarm bit
    localparam int NUM_ALARMS = $bits(alarm_t);

    alarm_t                  alarm_raw;
    logic [DEBOUNCE_LEN-1:0] hist [NUM_ALARMS];

    ////////////////////////////////////////
    // Polarity
    ////////////////////////////////////////

    // Power failure pin is active low
    assign alarm_raw = {~power_failure_n, voltage_alert};

    ////////////////////////////////////////
    // Sample history and debounce
    ////////////////////////////////////////

    // Leading history stages also resynchronise the async pins
    // Output moves only when the whole window agrees
    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            hist   <= '{default: '0};
            alarms <= '0;
        end else begin
            for (int i = 0; i < NUM_ALARMS; i++) begin
                // Newest sample in bit 0
                hist[i] <= {hist[i][DEBOUNCE_LEN-2:0], alarm_raw[i]};
                if (&hist[i]) begin
                    alarms[i] <= 1'b1;
                end else if (~|hist[i]) begin
                    alarms[i] <= 1'b0;
                end
                // Mixed window holds the last state
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/kvb_platform_pkg.sv ====
`default_nettype none

package kvb_platform_pkg;

    ////////////////////////////////////////
    // Board geometry and bus widths
    ////////////////////////////////////////

    // Peripheral slots on the backplane
    localparam int NUM_SLOTS = 7;

    // One bit per slot
    typedef logic [NUM_SLOTS-1:0] slot_vec_t;

    // LTSSM state code from the PCIe core
    typedef logic [4:0] ltssm_t;

    // Link counts as up in L0 and L0s only
    localparam ltssm_t LTSSM_L0  = 5'b01111;
    localparam ltssm_t LTSSM_L0S = 5'b10101;

    // Bit 0 voltage alert, bit 1 power failure, active high
    typedef logic [1:0] alarm_t;

    // User LED levels, active high
    typedef logic [1:0] user_led_t;

    ////////////////////////////////////////
    // Default timing constants
    ////////////////////////////////////////

    // 200 ns at 125 MHz
    localparam int DEF_RELEASE_DELAY    = 25;
    // Debounce window in samples
    localparam int DEF_DEBOUNCE_LEN     = 25;
    // Half period for about 16 kHz
    localparam int DEF_SYNC_HALF_PERIOD = 3906;

    // Reset sequencer states
    typedef enum logic [1:0] {
        HOLD,
        DELAY,
        RUN
    } rst_state_t;

endpackage

`default_nettype wire

// ==== hdl/kvb_platform_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module kvb_platform_top #(
    parameter int RELEASE_DELAY    = kvb_platform_pkg::DEF_RELEASE_DELAY,
    parameter int DEBOUNCE_LEN     = kvb_platform_pkg::DEF_DEBOUNCE_LEN,
    parameter int SYNC_HALF_PERIOD = kvb_platform_pkg::DEF_SYNC_HALF_PERIOD
) (
    input  wire                         clk125,
    input  wire                         sys_rst_n,

    // Power alarms from the supply
    input  wire                         voltage_alert,
    input  wire                         power_failure_n,

    // Slot presence pads, input side
    input  kvb_platform_pkg::slot_vec_t slot_prsnt_n,

    // From the PCIe core and the LED register
    input  kvb_platform_pkg::ltssm_t    ltssm,
    input  kvb_platform_pkg::user_led_t user_led,

    output kvb_platform_pkg::alarm_t    alarms,

    // Slot clock pads, data and enable
    output kvb_platform_pkg::slot_vec_t slot_sync_clk,
    output kvb_platform_pkg::slot_vec_t slot_clk_oe,
    // Open drain clock requests to the PCH
    output kvb_platform_pkg::slot_vec_t clk_req_oe,

    output logic                        link_led_n,
    output kvb_platform_pkg::user_led_t user_led_n
);

    logic rst_sync_n;
    logic rst_released;
    logic sync_clk;

    ////////////////////////////////////////
    // Reset and clocking
    ////////////////////////////////////////

    reset_sequencer #(
        .RELEASE_DELAY (RELEASE_DELAY)
    ) u_reset_sequencer (
        .clk125       (clk125),
        .sys_rst_n    (sys_rst_n),
        .rst_sync_n   (rst_sync_n),
        .rst_released (rst_released)
    );

    sync_clock_gen #(
        .SYNC_HALF_PERIOD (SYNC_HALF_PERIOD)
    ) u_sync_clock_gen (
        .clk125    (clk125),
        .sys_rst_n (sys_rst_n),
        .sync_clk  (sync_clk)
    );

    ////////////////////////////////////////
    // Slot presence and clocks
    ////////////////////////////////////////

    slot_clock_ctrl u_slot_clock_ctrl (
        .clk125        (clk125),
        .rst_sync_n    (rst_sync_n),
        .rst_released  (rst_released),
        .sync_clk      (sync_clk),
        .slot_prsnt_n  (slot_prsnt_n),
        .slot_sync_clk (slot_sync_clk),
        .slot_clk_oe   (slot_clk_oe),
        .clk_req_oe    (clk_req_oe)
    );

    ////////////////////////////////////////
    // Alarms and LEDs
    ////////////////////////////////////////

    alarm_filter #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) u_alarm_filter (
        .clk125          (clk125),
        .sys_rst_n       (sys_rst_n),
        .voltage_alert   (voltage_alert),
        .power_failure_n (power_failure_n),
        .alarms          (alarms)
    );

    status_indicators u_status_indicators (
        .clk125     (clk125),
        .sys_rst_n  (sys_rst_n),
        .ltssm      (ltssm),
        .user_led   (user_led),
        .link_led_n (link_led_n),
        .user_led_n (user_led_n)
    );

endmodule

`default_nettype wire

// ==== hdl/reset_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
    parameter int RELEASE_DELAY = kvb_platform_pkg::DEF_RELEASE_DELAY
) (
    input  wire  clk125,
    input  wire  sys_rst_n,
    output logic rst_sync_n,
    output logic rst_released
);

    import kvb_platform_pkg::*;

    // Counter wide enough for the full delay
    localparam int CNT_W = $clog2(RELEASE_DELAY + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RELEASE_DELAY - 1);

    logic [1:0]       sync_ff;
    rst_state_t       state;
    logic [CNT_W-1:0] cnt;

    ////////////////////////////////////////
    // Reset synchroniser
    ////////////////////////////////////////

    // Asserts asynchronously, releases on the second edge
    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sync_ff <= 2'b00;
        end else begin
            sync_ff <= {sync_ff[0], 1'b1};
        end
    end

    assign rst_sync_n = sync_ff[1];

    ////////////////////////////////////////
    // Release delay FSM
    ////////////////////////////////////////

    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= HOLD;
            cnt   <= '0;
        end else begin
            case (state)
                // Wait for synchronised release
                HOLD: begin
                    if (rst_sync_n) begin
                        state <= DELAY;
                        cnt   <= '0;
                    end
                end
                // Count out the release delay
                DELAY: begin
                    if (cnt == CNT_LAST) begin
                        state <= RUN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // Stays here until the next reset
                RUN: begin
                    state <= RUN;
                end
                default: begin
                    state <= HOLD;
                end
            endcase
        end
    end

    // Board released once in RUN
    assign rst_released = (state == RUN);

endmodule

`default_nettype wire

// ==== hdl/slot_clock_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_clock_ctrl (
    input  wire                         clk125,
    input  wire                         rst_sync_n,
    input  wire                         rst_released,
    input  wire                         sync_clk,
    input  kvb_platform_pkg::slot_vec_t slot_prsnt_n,
    output kvb_platform_pkg::slot_vec_t slot_sync_clk,
    output kvb_platform_pkg::slot_vec_t slot_clk_oe,
    output kvb_platform_pkg::slot_vec_t clk_req_oe
);

    import kvb_platform_pkg::*;

    slot_vec_t prsnt;

    ////////////////////////////////////////
    // Presence latch
    ////////////////////////////////////////

    // Clock enable pads read as presence while in reset
    // Value frozen once the synchronised reset releases
    always_ff @(posedge clk125) begin
        if (!rst_sync_n) begin
            prsnt <= ~slot_prsnt_n;
        end
    end

    ////////////////////////////////////////
    // Sync clock out to present slots
    ////////////////////////////////////////

    // Square wave only toward occupied slots
    assign slot_sync_clk = {NUM_SLOTS{sync_clk}} & prsnt;

    // Pad turns to output after the release delay
    // Until then the line stays an input for presence
    assign slot_clk_oe = rst_released ? prsnt : '0;

    ////////////////////////////////////////
    // PCIe clock requests
    ////////////////////////////////////////

    // Open drain, pad pulls low where enabled
    assign clk_req_oe = prsnt;

endmodule

`default_nettype wire

// ==== hdl/status_indicators.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_indicators (
    input  wire                         clk125,
    input  wire                         sys_rst_n,
    input  kvb_platform_pkg::ltssm_t    ltssm,
    input  kvb_platform_pkg::user_led_t user_led,
    output logic                        link_led_n,
    output kvb_platform_pkg::user_led_t user_led_n
);

    import kvb_platform_pkg::*;

    logic link_up;

    ////////////////////////////////////////
    // Link state decode
    ////////////////////////////////////////

    // L0 or L0s means link up
    assign link_up = (ltssm == LTSSM_L0) || (ltssm == LTSSM_L0S);

    ////////////////////////////////////////
    // LED drive
    ////////////////////////////////////////

    // All LEDs dark during reset
    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            link_led_n <= 1'b1;
            user_led_n <= '1;
        end else begin
            // Active low outputs
            link_led_n <= ~link_up;
            user_led_n <= ~user_led;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sync_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_clock_gen #(
    parameter int SYNC_HALF_PERIOD = kvb_platform_pkg::DEF_SYNC_HALF_PERIOD
) (
    input  wire  clk125,
    input  wire  sys_rst_n,
    output logic sync_clk
);

    // Counter spans one half period
    localparam int CNT_W = $clog2(SYNC_HALF_PERIOD + 1);
    localparam logic [CNT_W-1:0] CNT_TERM = CNT_W'(SYNC_HALF_PERIOD - 1);

    logic [CNT_W-1:0] half_cnt;

    ////////////////////////////////////////
    // Half period divider
    ////////////////////////////////////////

    // Terminal count flips the square wave
    // Output is a plain register on clk125, not a derived clock
    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            half_cnt <= '0;
            sync_clk <= 1'b0;
        end else begin
            if (half_cnt == CNT_TERM) begin
                half_cnt <= '0;
                sync_clk <= ~sync_clk;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== kvb_platform_top.f ====
hdl/kvb_platform_pkg.sv
hdl/reset_sequencer.sv
hdl/alarm_filter.sv
hdl/sync_clock_gen.sv
hdl/slot_clock_ctrl.sv
hdl/status_indicators.sv
hdl/kvb_platform_top.sv
dv/kvb_platform_props.sv
dv/kvb_platform_tb.sv
